// ==== runSim.sh ====
#!/bin/sh
# build and run the tinyCpu16 testbench, the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
	-f tinyCpu16.f -o cpuSim

./obj_dir/cpuSim > sim.log
cat sim.log

grep -q "Simulation completed successfully" sim.log

// ==== src/aluUnit.sv ====
module aluUnit (
	input cpuPkg::aluOp_t op,
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input logic cin,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flagsOut
);
	import cpuPkg::*;

	logic [WordBits:0] wide; // extra bit is carry or borrow
	logic isAdd;
	logic isSub;

	assign isAdd = (op == AluAdd) || (op == AluAdc);
	assign isSub = (op == AluSub) || (op == AluSuc);

	always_comb begin
		wide = '0;
		case (op)
			AluAdd: wide = {1'b0, a} + {1'b0, b};
			AluAdc: wide = {1'b0, a} + {1'b0, b} + {{WordBits{1'b0}}, cin};
			AluSub: wide = {1'b0, a} - {1'b0, b};
			AluSuc: wide = {1'b0, a} - {1'b0, b} - {{WordBits{1'b0}}, cin};
			AluAnd: wide[WordBits-1:0] = a & b;
			AluOr: wide[WordBits-1:0] = a | b;
			AluXor: wide[WordBits-1:0] = a ^ b;
			AluNeg: wide[WordBits-1:0] = ~a;
			AluNot: wide[WordBits-1:0] = {{(WordBits-1){1'b0}}, (a == '0)};
			AluShl: wide[WordBits-1:0] = a << 1;
			AluShr: wide[WordBits-1:0] = a >> 1;
			default: wide = '0;
		endcase
	end

	assign result = wide[WordBits-1:0];

	always_comb begin
		flagsOut.zf = (result == '0);
		flagsOut.cf = (isAdd || isSub) && wide[WordBits];
		if (isAdd) begin // same signs in, other sign out
			flagsOut.of = (a[WordBits-1] == b[WordBits-1]) &&
				(result[WordBits-1] != a[WordBits-1]);
		end else if (isSub) begin
			flagsOut.of = (a[WordBits-1] != b[WordBits-1]) &&
				(result[WordBits-1] != a[WordBits-1]);
		end else begin
			flagsOut.of = 1'b0;
		end
	end

endmodule

// ==== src/commitStage.sv ====
module commitStage (
	input logic clk,
	input logic reset,
	commitIf.consumer commit,
	output logic regWrite,
	output cpuPkg::regSel_t regDst,
	output cpuPkg::word_t regData,
	output logic regWrite2,
	output cpuPkg::regSel_t regDst2,
	output cpuPkg::word_t regData2,
	output logic flagWrite,
	output cpuPkg::flags_t flagsOut,
	output logic spWrite,
	output cpuPkg::word_t spData,
	output logic bpWrite,
	output cpuPkg::word_t bpData,
	output logic ramWrite,
	output cpuPkg::word_t ramAddr,
	output cpuPkg::word_t ramData,
	output logic stackWrite,
	output cpuPkg::word_t stackWrAddr,
	output cpuPkg::word_t stackData,
	output logic stackWrite2,
	output cpuPkg::word_t stackData2,
	output logic pcLoad,
	output cpuPkg::word_t newPc,
	output logic outValid,
	output cpuPkg::word_t outLine
);

	// enables last exactly the commit cycle
	assign regWrite = commit.valid & commit.regWrite;
	assign regWrite2 = commit.valid & commit.regWrite2;
	assign flagWrite = commit.valid & commit.flagWrite;
	assign spWrite = commit.valid & commit.spWrite;
	assign bpWrite = commit.valid & commit.bpWrite;
	assign ramWrite = commit.valid & commit.ramWrite;
	assign stackWrite = commit.valid & commit.stackWrite;
	assign stackWrite2 = commit.valid & commit.stackWrite2;

	assign regDst = commit.regDst;
	assign regData = commit.regData;
	assign regDst2 = commit.regDst2;
	assign regData2 = commit.regData2;
	assign flagsOut = commit.flags;
	assign spData = commit.spData;
	assign bpData = commit.bpData;
	assign ramAddr = commit.ramAddr;
	assign ramData = commit.ramData;
	assign stackWrAddr = commit.stackAddr;
	assign stackData = commit.stackData;
	assign stackData2 = commit.stackData2;

	assign pcLoad = commit.valid; // fetch resumes after every commit
	assign newPc = commit.nextPc;

	always_ff @(posedge clk) begin
		if (!reset) begin
			outValid <= 1'b0;
			outLine <= '0;
		end else begin
			outValid <= commit.valid & commit.outValid;
			if (commit.valid && commit.outValid) begin
				outLine <= commit.outData;
			end
		end
	end

endmodule

// ==== src/cpuPkg.sv ====
package cpuPkg;

	localparam int WordBits = 16;
	localparam int RamWords = 2048;
	localparam int StackWords = 1024;
	localparam int RamAddrBits = $clog2(RamWords); // addresses wrap to 11 bits
	localparam int StackAddrBits = $clog2(StackWords); // and to 10 bits here
	localparam int FetchWords = 3; // opcode, par1, par2

	typedef logic [WordBits-1:0] word_t;

	// 0 ax, 1 bx, 2 cx, 3 dx
	typedef logic [1:0] regSel_t;
	localparam regSel_t RegDx = 2'd3; // target of the flag copies

	typedef struct packed {
		logic [11:0] pad;
		regSel_t dst; // bits 3..2
		regSel_t src; // bits 1..0, also the single register of unary ops
	} regPair_t;

	// par1/par2 are either a register pair or an immediate/address
	typedef union packed {
		word_t raw;
		regPair_t regPair;
	} operand_t;

	// length 1: NOP CFF COF CZF RET, 3: MOV1 MOV2 MOV4 MOV5 MOV6, else 2
	typedef enum logic [15:0] {
		OpNop = 16'h00, OpCff = 16'h02, OpCof = 16'h03, OpCzf = 16'h04,
		OpMov1 = 16'h05, OpMov2 = 16'h06, OpMov3 = 16'h07, OpMov4 = 16'h08,
		OpPop = 16'h09, OpOut = 16'h0A, OpPush = 16'h0B,
		OpAdd = 16'h0C, OpAdc = 16'h0D, OpSub = 16'h0E, OpSuc = 16'h0F,
		OpCmp = 16'h14, OpAnd = 16'h15, OpNeg = 16'h16, OpNot = 16'h17,
		OpOr = 16'h18, OpShl = 16'h19, OpShr = 16'h1A, OpXor = 16'h1B,
		OpTest = 16'h1C, OpCall = 16'h1E, OpRet = 16'h1F,
		OpJmp1 = 16'h20, OpJc = 16'h21, OpJnc = 16'h22, OpJz = 16'h23,
		OpJnz = 16'h24, OpJo = 16'h25, OpJno = 16'h26,
		OpMov5 = 16'h2A, OpMov6 = 16'h2B, OpJmp2 = 16'h31
	} opcode_t;

	typedef enum logic [3:0] {
		AluAdd = 4'd0,
		AluAdc = 4'd1,
		AluSub = 4'd2,
		AluSuc = 4'd3,
		AluAnd = 4'd4,
		AluOr = 4'd5,
		AluXor = 4'd6,
		AluNeg = 4'd7, // bitwise invert
		AluNot = 4'd8, // logical not
		AluShl = 4'd9,
		AluShr = 4'd10
	} aluOp_t;

	typedef struct packed {
		logic cf;
		logic zf;
		logic of;
	} flags_t;

endpackage

// ==== src/cpuTop.sv ====
module cpuTop (
	input logic clk,
	input logic reset,
	input logic loadEn,
	input cpuPkg::word_t loadAddr,
	input cpuPkg::word_t loadData,
	output logic outValid,
	output cpuPkg::word_t outLine
);
	import cpuPkg::*;

	word_t fetchAddr;
	word_t fetchWords [FetchWords];
	logic pcLoad;
	word_t newPc;
	word_t dataAddr;
	word_t dataWord;
	word_t stackAddr;
	word_t stackWord;
	word_t regs [4];
	word_t sp;
	word_t bp;
	flags_t flags;
	logic regWrite;
	regSel_t regDst;
	word_t regData;
	logic regWrite2;
	regSel_t regDst2;
	word_t regData2;
	logic flagWrite;
	flags_t flagsNext;
	logic spWrite;
	word_t spData;
	logic bpWrite;
	word_t bpData;
	logic ramWrite;
	word_t ramAddr;
	word_t ramData;
	logic stackWrite;
	word_t stackWrAddr;
	word_t stackData;
	logic stackWrite2;
	word_t stackData2;

	instrIf instrBus ();
	commitIf commitBus ();

	mainMemory memory (
		.clk(clk), .reset(reset), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.fetchAddr(fetchAddr), .fetchWords(fetchWords), .dataAddr(dataAddr),
		.dataWord(dataWord), .stackAddr(stackAddr), .stackWord(stackWord),
		.ramWrite(ramWrite), .ramAddr(ramAddr), .ramData(ramData),
		.stackWrite(stackWrite), .stackWrAddr(stackWrAddr), .stackData(stackData),
		.stackWrite2(stackWrite2), .stackData2(stackData2)
	);

	registerFile regFile (
		.clk(clk), .reset(reset), .regWrite(regWrite), .regDst(regDst), .regData(regData),
		.regWrite2(regWrite2), .regDst2(regDst2), .regData2(regData2),
		.spWrite(spWrite), .spData(spData), .bpWrite(bpWrite), .bpData(bpData),
		.flagWrite(flagWrite), .flagsIn(flagsNext), .regs(regs), .sp(sp), .bp(bp),
		.flags(flags)
	);

	fetchStage fetch (
		.clk(clk), .reset(reset), .fetchWords(fetchWords), .fetchAddr(fetchAddr),
		.pcLoad(pcLoad), .newPc(newPc), .instr(instrBus.producer)
	);

	executeStage execute (
		.clk(clk), .reset(reset), .instr(instrBus.consumer), .regs(regs), .sp(sp), .bp(bp),
		.flags(flags), .dataAddr(dataAddr), .stackAddr(stackAddr), .dataWord(dataWord),
		.stackWord(stackWord), .commit(commitBus.producer)
	);

	commitStage commit (
		.clk(clk), .reset(reset), .commit(commitBus.consumer),
		.regWrite(regWrite), .regDst(regDst), .regData(regData),
		.regWrite2(regWrite2), .regDst2(regDst2), .regData2(regData2),
		.flagWrite(flagWrite), .flagsOut(flagsNext), .spWrite(spWrite), .spData(spData),
		.bpWrite(bpWrite), .bpData(bpData), .ramWrite(ramWrite), .ramAddr(ramAddr),
		.ramData(ramData), .stackWrite(stackWrite), .stackWrAddr(stackWrAddr),
		.stackData(stackData), .stackWrite2(stackWrite2), .stackData2(stackData2),
		.pcLoad(pcLoad), .newPc(newPc), .outValid(outValid), .outLine(outLine)
	);

endmodule

// ==== src/executeStage.sv ====
module executeStage (
	input logic clk,
	input logic reset,
	instrIf.consumer instr,
	input cpuPkg::word_t regs [4],
	input cpuPkg::word_t sp,
	input cpuPkg::word_t bp,
	input cpuPkg::flags_t flags,
	output cpuPkg::word_t dataAddr,
	output cpuPkg::word_t stackAddr,
	input cpuPkg::word_t dataWord,
	input cpuPkg::word_t stackWord,
	commitIf.producer commit
);
	import cpuPkg::*;

	opcode_t op;
	operand_t p1;
	operand_t p2;
	logic unary;
	regSel_t target;
	word_t instrLen;
	word_t seqPc;
	word_t jumpTarget;
	word_t stackTop; // stack[sp-1], picked up while idle
	logic taken;
	aluOp_t aluOp;
	word_t aluResult;
	flags_t aluFlags;

	assign op = instr.opcode;
	assign p1 = instr.par1;
	assign p2 = instr.par2;
	assign unary = op inside {OpNeg, OpNot, OpShl, OpShr};
	assign target = unary ? p1.regPair.src : p1.regPair.dst;
	assign seqPc = instr.pc + instrLen;
	assign jumpTarget = p1.raw + bp; // bp-relative target

	assign dataAddr = (op == OpMov2) ? p2.raw + bp : p2.raw;
	// RET pulls the return pc here, bp comes from stackTop
	assign stackAddr = (instr.valid && op == OpRet) ? sp - 16'd2 : sp - 16'd1;

	always_comb begin
		case (op)
			OpNop, OpCff, OpCof, OpCzf, OpRet: instrLen = 16'd1;
			OpMov1, OpMov2, OpMov4, OpMov5, OpMov6: instrLen = 16'd3;
			OpMov3, OpPop, OpOut, OpPush, OpAdd, OpAdc, OpSub, OpSuc, OpCmp,
			OpAnd, OpNeg, OpNot, OpOr, OpShl, OpShr, OpXor, OpTest, OpCall,
			OpJmp1, OpJmp2, OpJc, OpJnc, OpJz, OpJnz, OpJo, OpJno: instrLen = 16'd2;
			default: instrLen = 16'd1; // unknown opcode runs as NOP
		endcase
	end

	always_comb begin
		case (op)
			OpAdc: aluOp = AluAdc;
			OpSub, OpCmp: aluOp = AluSub;
			OpSuc: aluOp = AluSuc;
			OpAnd: aluOp = AluAnd;
			OpOr: aluOp = AluOr;
			OpXor: aluOp = AluXor;
			OpNeg: aluOp = AluNeg;
			OpNot: aluOp = AluNot;
			OpShl: aluOp = AluShl;
			OpShr: aluOp = AluShr;
			default: aluOp = AluAdd;
		endcase
	end

	always_comb begin
		case (op)
			OpJmp1: taken = 1'b1;
			OpJc: taken = flags.cf;
			OpJnc: taken = !flags.cf;
			OpJz: taken = flags.zf;
			OpJnz: taken = !flags.zf;
			OpJo: taken = flags.of;
			OpJno: taken = !flags.of;
			default: taken = 1'b0;
		endcase
	end

	aluUnit alu (
		.op(aluOp),
		.a(regs[target]),
		.b(regs[p1.regPair.src]),
		.cin(flags.cf),
		.result(aluResult),
		.flagsOut(aluFlags)
	);

	always_ff @(posedge clk) begin
		if (!reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= instr.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!instr.valid) begin
			stackTop <= stackWord;
		end
	end

	// record is rebuilt every cycle, commit only honours it with valid
	always_ff @(posedge clk) begin
		commit.nextPc <= seqPc;
		commit.regWrite <= 1'b0;
		commit.regDst <= target;
		commit.regData <= aluResult;
		commit.regWrite2 <= 1'b0;
		commit.regDst2 <= p1.regPair.src;
		commit.regData2 <= stackWord;
		commit.flagWrite <= 1'b0;
		commit.flags <= aluFlags;
		commit.ramWrite <= 1'b0;
		commit.ramAddr <= p1.raw;
		commit.ramData <= regs[p2.regPair.src];
		commit.stackWrite <= 1'b0;
		commit.stackAddr <= sp;
		commit.stackData <= regs[p1.regPair.src];
		commit.stackWrite2 <= 1'b0;
		commit.stackData2 <= bp;
		commit.spWrite <= 1'b0;
		commit.spData <= sp + 16'd1;
		commit.bpWrite <= 1'b0;
		commit.bpData <= p1.raw;
		commit.outValid <= 1'b0;
		commit.outData <= regs[p1.regPair.src];
		case (op)
			OpMov1: begin
				commit.ramWrite <= 1'b1;
				commit.ramAddr <= jumpTarget; // par1+bp
			end
			OpMov5: commit.ramWrite <= 1'b1;
			OpMov2, OpMov6: begin
				commit.regWrite <= 1'b1;
				commit.regDst <= p1.regPair.src;
				commit.regData <= dataWord;
			end
			OpMov3: begin
				commit.regWrite <= 1'b1;
				commit.regData <= regs[p1.regPair.src];
			end
			OpMov4: begin
				commit.regWrite <= 1'b1;
				commit.regDst <= p1.regPair.src;
				commit.regData <= p2.raw;
			end
			OpCff, OpCof, OpCzf: begin
				commit.regWrite <= 1'b1;
				commit.regDst <= RegDx;
				commit.regData <= (op == OpCff) ? {15'd0, flags.cf} :
					(op == OpCof) ? {15'd0, flags.of} : {15'd0, flags.zf};
			end
			OpPush: begin
				commit.stackWrite <= 1'b1;
				commit.spWrite <= 1'b1;
			end
			OpPop: begin
				commit.regWrite2 <= 1'b1;
				commit.spWrite <= 1'b1;
				commit.spData <= sp - 16'd1;
			end
			OpOut: commit.outValid <= 1'b1;
			OpAdd, OpAdc, OpSub, OpSuc: begin
				commit.regWrite <= 1'b1;
				commit.flagWrite <= 1'b1;
			end
			OpCmp: commit.flagWrite <= 1'b1;
			OpAnd, OpOr, OpXor, OpNeg, OpNot, OpShl, OpShr: commit.regWrite <= 1'b1;
			OpTest: begin
				commit.flagWrite <= 1'b1;
				commit.flags <= '{cf: flags.cf,
					zf: (regs[p1.regPair.dst] == regs[p1.regPair.src]), of: flags.of};
			end
			OpCall: begin
				commit.stackWrite <= 1'b1; // return pc at sp
				commit.stackData <= seqPc;
				commit.stackWrite2 <= 1'b1; // bp at sp+1
				commit.spWrite <= 1'b1;
				commit.spData <= sp + 16'd2;
				commit.bpWrite <= 1'b1;
				commit.nextPc <= jumpTarget;
			end
			OpRet: begin
				commit.nextPc <= stackWord;
				commit.bpWrite <= 1'b1;
				commit.bpData <= stackTop;
				commit.spWrite <= 1'b1;
				commit.spData <= sp - 16'd2;
			end
			OpJmp2: commit.nextPc <= p1.raw; // absolute
			OpJmp1, OpJc, OpJnc, OpJz, OpJnz, OpJo, OpJno: begin
				if (taken) begin
					commit.nextPc <= jumpTarget;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== src/fetchStage.sv ====
module fetchStage (
	input logic clk,
	input logic reset,
	input cpuPkg::word_t fetchWords [cpuPkg::FetchWords],
	output cpuPkg::word_t fetchAddr,
	input logic pcLoad,
	input cpuPkg::word_t newPc,
	instrIf.producer instr
);
	import cpuPkg::*;

	word_t pc;
	logic waiting; // one instruction in flight

	assign fetchAddr = pc;

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			waiting <= 1'b0;
			instr.valid <= 1'b0;
		end else begin
			instr.valid <= 1'b0;
			if (pcLoad) begin // commit redirects every instruction
				pc <= newPc;
				waiting <= 1'b0;
			end else if (!waiting) begin
				instr.valid <= 1'b1;
				instr.pc <= pc;
				instr.opcode <= opcode_t'(fetchWords[0]);
				instr.par1 <= fetchWords[1];
				instr.par2 <= fetchWords[2];
				waiting <= 1'b1;
			end
		end
	end

endmodule

// ==== src/mainMemory.sv ====
module mainMemory (
	input logic clk,
	input logic reset,
	input logic loadEn,
	input cpuPkg::word_t loadAddr,
	input cpuPkg::word_t loadData,
	input cpuPkg::word_t fetchAddr,
	output cpuPkg::word_t fetchWords [cpuPkg::FetchWords],
	input cpuPkg::word_t dataAddr,
	output cpuPkg::word_t dataWord,
	input cpuPkg::word_t stackAddr,
	output cpuPkg::word_t stackWord,
	input logic ramWrite,
	input cpuPkg::word_t ramAddr,
	input cpuPkg::word_t ramData,
	input logic stackWrite,
	input cpuPkg::word_t stackWrAddr,
	input cpuPkg::word_t stackData,
	input logic stackWrite2,
	input cpuPkg::word_t stackData2
);
	import cpuPkg::*;

	word_t ram [RamWords]; // program and data
	word_t stack [StackWords];

	for (genvar i = 0; i < FetchWords; i++) begin : gFetch
		assign fetchWords[i] = ram[RamAddrBits'(fetchAddr + word_t'(i))]; // pc, pc+1, pc+2
	end

	assign dataWord = ram[RamAddrBits'(dataAddr)];
	assign stackWord = stack[StackAddrBits'(stackAddr)];

	always_ff @(posedge clk) begin
		if (!reset && loadEn) begin // image load only while held in reset
			ram[RamAddrBits'(loadAddr)] <= loadData;
		end else if (ramWrite) begin
			ram[RamAddrBits'(ramAddr)] <= ramData;
		end
	end

	always_ff @(posedge clk) begin
		if (stackWrite) begin
			stack[StackAddrBits'(stackWrAddr)] <= stackData;
		end
		if (stackWrite2) begin
			stack[StackAddrBits'(stackWrAddr + 16'd1)] <= stackData2;
		end
	end

endmodule

// ==== src/registerFile.sv ====
module registerFile (
	input logic clk,
	input logic reset,
	input logic regWrite,
	input cpuPkg::regSel_t regDst,
	input cpuPkg::word_t regData,
	input logic regWrite2,
	input cpuPkg::regSel_t regDst2,
	input cpuPkg::word_t regData2,
	input logic spWrite,
	input cpuPkg::word_t spData,
	input logic bpWrite,
	input cpuPkg::word_t bpData,
	input logic flagWrite,
	input cpuPkg::flags_t flagsIn,
	output cpuPkg::word_t regs [4],
	output cpuPkg::word_t sp,
	output cpuPkg::word_t bp,
	output cpuPkg::flags_t flags
);
	import cpuPkg::*;

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
			sp <= '0;
			bp <= '0;
			flags <= '0;
		end else begin
			if (regWrite) begin
				regs[regDst] <= regData;
			end
			if (regWrite2) begin
				regs[regDst2] <= regData2; // last write wins on a clash
			end
			if (spWrite) begin
				sp <= spData;
			end
			if (bpWrite) begin
				bp <= bpData;
			end
			if (flagWrite) begin
				flags <= flagsIn;
			end
		end
	end

endmodule

// ==== src/stageIf.sv ====
interface instrIf;
	import cpuPkg::*;

	logic valid; // one-cycle pulse per issued instruction
	word_t pc;
	opcode_t opcode;
	operand_t par1;
	operand_t par2;

	modport producer (output valid, pc, opcode, par1, par2);
	modport consumer (input valid, pc, opcode, par1, par2);
endinterface

interface commitIf;
	import cpuPkg::*;

	logic valid;
	word_t nextPc;
	logic regWrite;
	regSel_t regDst;
	word_t regData;
	logic regWrite2; // POP load
	regSel_t regDst2;
	word_t regData2;
	logic flagWrite;
	flags_t flags;
	logic ramWrite;
	word_t ramAddr;
	word_t ramData;
	logic stackWrite;
	word_t stackAddr;
	word_t stackData;
	logic stackWrite2; // second CALL word, at stackAddr+1
	word_t stackData2;
	logic spWrite;
	word_t spData;
	logic bpWrite;
	word_t bpData;
	logic outValid;
	word_t outData;

	modport producer (output valid, nextPc, regWrite, regDst, regData, regWrite2, regDst2,
		regData2, flagWrite, flags, ramWrite, ramAddr, ramData, stackWrite, stackAddr,
		stackData, stackWrite2, stackData2, spWrite, spData, bpWrite, bpData, outValid,
		outData);
	modport consumer (input valid, nextPc, regWrite, regDst, regData, regWrite2, regDst2,
		regData2, flagWrite, flags, ramWrite, ramAddr, ramData, stackWrite, stackAddr,
		stackData, stackWrite2, stackData2, spWrite, spData, bpWrite, bpData, outValid,
		outData);
endinterface

// ==== tinyCpu16.f ====
+incdir+verif
src/cpuPkg.sv
src/stageIf.sv
src/mainMemory.sv
src/registerFile.sv
src/fetchStage.sv
src/aluUnit.sv
src/executeStage.sv
src/commitStage.sv
src/cpuTop.sv
verif/cpuTb.sv

// ==== verif/cpuPrograms.svh ====
function automatic word_t regPair(input regSel_t dst, input regSel_t src);
	return {12'd0, dst, src};
endfunction

task automatic emitWord(input word_t w);
	imgAddr.push_back(asmPc);
	imgData.push_back(w);
	asmPc = asmPc + 16'd1;
endtask

task automatic placeAt(input word_t addr);
	asmPc = addr;
endtask

task automatic oneWord(input opcode_t op);
	emitWord(op);
endtask

task automatic twoWords(input opcode_t op, input word_t p1);
	emitWord(op);
	emitWord(p1);
endtask

task automatic threeWords(input opcode_t op, input word_t p1, input word_t p2);
	emitWord(op);
	emitWord(p1);
	emitWord(p2);
endtask

task automatic expectOut(input word_t w);
	expQ.push_back(w);
endtask

task automatic endProgram();
	twoWords(OpJmp2, asmPc); // spin on itself
endtask

// branch picks marker or marker+1 into dx, then OUT dx
task automatic flagCheck(input opcode_t jop, input logic flagSet, input word_t marker);
	word_t p;
	p = asmPc;
	twoWords(jop, p + 16'd7);
	threeWords(OpMov4, 16'd3, marker);
	twoWords(OpJmp1, p + 16'd10);
	threeWords(OpMov4, 16'd3, marker + 16'd1);
	twoWords(OpOut, 16'd3);
	expectOut(flagSet ? marker + 16'd1 : marker);
endtask

// ax op bx with the flag rules worked out in integers
task automatic arithStep(input opcode_t op, input word_t a, input word_t b);
	int u;
	int r;
	int cin;
	word_t res;
	cin = (op == OpAdc || op == OpSuc) ? int'(mCf) : 0;
	if (op == OpAdd || op == OpAdc) begin
		u = int'(a) + int'(b) + cin;
		r = int'($signed(a)) + int'($signed(b)) + cin;
		mCf = (u > 65535);
	end else begin
		u = int'(a) - int'(b) - cin;
		r = int'($signed(a)) - int'($signed(b)) - cin;
		mCf = (u < 0); // borrow
	end
	res = word_t'(u);
	mZf = (res == 16'd0);
	mOf = (r > 32767) || (r < -32768);
	threeWords(OpMov4, 16'd0, a);
	threeWords(OpMov4, 16'd1, b);
	twoWords(op, regPair(2'd0, 2'd1));
	twoWords(OpOut, 16'd0);
	expectOut(op == OpCmp ? a : res); // CMP leaves ax alone
	flagCheck(OpJc, mCf, 16'hC000);
	flagCheck(OpJz, mZf, 16'hD000);
	flagCheck(OpJo, mOf, 16'hE000);
endtask

task automatic logicStep(input opcode_t op, input word_t a, input word_t p1, input word_t exp);
	threeWords(OpMov4, 16'd0, a);
	twoWords(op, p1);
	twoWords(OpOut, 16'd0);
	expectOut(exp);
endtask

task automatic copyFlag(input opcode_t op, input logic flagSet);
	oneWord(op);
	twoWords(OpOut, 16'd3);
	expectOut({15'd0, flagSet});
endtask

// ==== verif/cpuTb.sv ====
module cpuTb;
	import cpuPkg::*;

	localparam int TimeoutCycles = 4000;

	logic clk;
	logic reset;
	logic loadEn;
	word_t loadAddr;
	word_t loadData;
	logic outValid;
	word_t outLine;

	word_t imgAddr [$];
	word_t imgData [$];
	word_t expQ [$];
	word_t asmPc;
	logic mCf;
	logic mZf;
	logic mOf;
	integer seed = 32'h8eda_44dd;
	int outCount;
	int mismatchErrors;
	int resetErrors;
	int timeoutErrors;

	`include "cpuPrograms.svh"

	cpuTop dut_i (
		.clk(clk), .reset(reset), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadData(loadData), .outValid(outValid), .outLine(outLine)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (reset && outValid === 1'b1) begin
			outputMatches: assert (expQ.size() > 0 && outLine == expQ[0])
			else begin
				mismatchErrors++;
				$display("ERROR at time %0t: outLine %h, expected %h", $time, outLine,
					expQ.size() > 0 ? expQ[0] : 16'hxxxx);
			end
			if (expQ.size() > 0) begin
				void'(expQ.pop_front());
			end
			outCount++;
		end
		if (!reset) begin
			quietInReset: assert (outValid !== 1'b1)
			else begin
				resetErrors++;
				$display("ERROR at time %0t: outValid high while reset is low", $time);
			end
		end
	end

	task automatic buildMoves();
		word_t v [4];
		for (int i = 0; i < 4; i++) begin
			v[i] = word_t'($random(seed));
			threeWords(OpMov4, word_t'(i), v[i]);
			twoWords(OpOut, word_t'(i));
			expectOut(v[i]);
		end
		twoWords(OpMov3, regPair(2'd2, 2'd0)); // cx <- ax
		twoWords(OpMov3, regPair(2'd0, 2'd1)); // ax <- bx
		twoWords(OpOut, 16'd2);
		twoWords(OpOut, 16'd0);
		twoWords(OpOut, 16'd3);
		expectOut(v[0]);
		expectOut(v[1]);
		expectOut(v[3]);
	endtask

	task automatic buildArith();
		for (int k = 0; k < 3; k++) begin
			arithStep(OpAdd, word_t'($random(seed)), word_t'($random(seed)));
			arithStep(OpAdc, word_t'($random(seed)), word_t'($random(seed)));
			arithStep(OpSub, word_t'($random(seed)), word_t'($random(seed)));
			arithStep(OpSuc, word_t'($random(seed)), word_t'($random(seed)));
			arithStep(OpCmp, word_t'($random(seed)), word_t'($random(seed)));
		end
	endtask

	task automatic buildLogic();
		word_t a;
		word_t b;
		a = word_t'($random(seed));
		b = a ^ word_t'($random(seed) | 1); // never equal to a
		arithStep(OpCmp, a, b); // known flags, bx = b
		logicStep(OpAnd, a, 16'd1, a & b);
		logicStep(OpOr, a, 16'd1, a | b);
		logicStep(OpXor, a, 16'd1, a ^ b);
		logicStep(OpNeg, a, 16'd0, ~a);
		logicStep(OpNot, a, 16'd0, {15'd0, a == 16'd0});
		logicStep(OpShl, a, 16'd0, {a[14:0], 1'b0});
		logicStep(OpShr, a, 16'd0, {1'b0, a[15:1]});
		copyFlag(OpCff, mCf);
		copyFlag(OpCof, mOf);
		copyFlag(OpCzf, mZf);
		threeWords(OpMov4, 16'd0, a);
		threeWords(OpMov4, 16'd2, a);
		twoWords(OpTest, regPair(2'd0, 2'd2)); // equal pair
		copyFlag(OpCzf, 1'b1);
		copyFlag(OpCff, mCf);
		twoWords(OpTest, regPair(2'd0, 2'd1));
		copyFlag(OpCzf, 1'b0);
		copyFlag(OpCof, mOf);
	endtask

	task automatic buildMemStack();
		word_t v [3];
		word_t w;
		word_t mainPc;
		w = word_t'($random(seed));
		threeWords(OpMov4, 16'd0, w);
		threeWords(OpMov5, 16'h0300, 16'd0); // ram[0x300] <- ax
		threeWords(OpMov4, 16'd0, 16'd0);
		threeWords(OpMov6, 16'd1, 16'h0300);
		twoWords(OpOut, 16'd1);
		expectOut(w);
		for (int i = 0; i < 3; i++) begin
			v[i] = word_t'($random(seed));
			threeWords(OpMov4, word_t'(i), v[i]);
			twoWords(OpPush, word_t'(i));
		end
		for (int i = 0; i < 3; i++) begin
			twoWords(OpPop, word_t'(i));
		end
		for (int i = 0; i < 3; i++) begin
			twoWords(OpOut, word_t'(i));
			expectOut(v[2 - i]); // LIFO order
		end
		w = word_t'($random(seed));
		threeWords(OpMov4, 16'd0, w);
		twoWords(OpCall, 16'h0200);
		mainPc = asmPc;
		placeAt(16'h0200); // bp becomes 0x200 in here
		threeWords(OpMov1, 16'h0040, 16'd0);
		threeWords(OpMov2, 16'd1, 16'h0040);
		twoWords(OpOut, 16'd1);
		threeWords(OpMov6, 16'd2, 16'h0240);
		twoWords(OpOut, 16'd2);
		threeWords(OpMov4, 16'd3, 16'h5B5B);
		twoWords(OpOut, 16'd3);
		oneWord(OpRet);
		expectOut(w);
		expectOut(w);
		expectOut(16'h5B5B);
		placeAt(mainPc);
		twoWords(OpJmp1, mainPc + 16'd4); // lands right only with bp back at 0
		twoWords(OpOut, 16'd0);
		threeWords(OpMov4, 16'd3, 16'h600D);
		twoWords(OpOut, 16'd3);
		expectOut(16'h600D);
	endtask

	task automatic buildLoop();
		int n;
		word_t top;
		n = 3 + ($random(seed) & 7);
		threeWords(OpMov4, 16'd0, word_t'(n));
		threeWords(OpMov4, 16'd1, 16'd1);
		top = asmPc;
		twoWords(OpOut, 16'd0);
		twoWords(OpSub, regPair(2'd0, 2'd1));
		twoWords(OpJnz, top);
		for (int i = n; i >= 1; i--) begin
			expectOut(word_t'(i));
		end
	endtask

	task automatic runProgram(input int prog);
		int total;
		int cycles;
		total = expQ.size();
		@(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < imgAddr.size(); i++) begin
			@(posedge clk);
			loadEn <= 1'b1;
			loadAddr <= imgAddr[i];
			loadData <= imgData[i];
		end
		@(posedge clk);
		loadEn <= 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b1;
		outCount = 0;
		cycles = 0;
		while (outCount < total && cycles < TimeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		if (outCount < total) begin
			timeoutErrors++;
			$display("Timeout: program %0d printed %0d of %0d words", prog, outCount, total);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		for (int prog = 1; prog <= 5; prog++) begin
			imgAddr.delete();
			imgData.delete();
			expQ.delete();
			asmPc = '0;
			{mCf, mZf, mOf} = 3'b000; // flags clear on reset
			case (prog)
				1: buildMoves();
				2: buildArith();
				3: buildLogic();
				4: buildMemStack();
				default: buildLoop();
			endcase
			endProgram();
			runProgram(prog);
		end
		repeat (4) @(posedge clk);
		$display("Errors: %0d mismatch, %0d reset, %0d timeout", mismatchErrors,
			resetErrors, timeoutErrors);
		if (mismatchErrors + resetErrors + timeoutErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
